//--- include/mdu_macros.svh
// Data width and RV32M encoding macros for the multiply/divide unit
`ifndef MDU_MACROS_SVH
`define MDU_MACROS_SVH

// Operand and result word size
`define MDU_XLEN 32

// Major opcode of register-register ALU instructions
`define MDU_OPCODE_OP 7'b011_0011

// funct7 that selects the M extension
`define MDU_FUNCT7_MULDIV 7'b000_0001

`endif

//--- hdl/mdu_pkg.sv
// Package with operation enums, control and payload structs, illegal control default
`include "mdu_macros.svh"

package mdu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Operation encodings
  //////////////////////////////////////////////////////////////////////

  // Multiplier output word select
  typedef enum logic {
    MUL_M32 = 1'b0,
    MUL_H   = 1'b1
  } mul_op_e;

  // Divider operation, bit 0 set means unsigned
  typedef enum logic [1:0] {
    DIV_DIV  = 2'b00,
    DIV_DIVU = 2'b01,
    DIV_REM  = 2'b10,
    DIV_REMU = 2'b11
  } div_op_e;

  //////////////////////////////////////////////////////////////////////
  // Request, control and result
  //////////////////////////////////////////////////////////////////////

  // Incoming request
  typedef struct packed {
    logic [`MDU_XLEN-1:0] instr;
    logic [`MDU_XLEN-1:0] rs1;
    logic [`MDU_XLEN-1:0] rs2;
  } mdu_req_t;

  // Decoded control
  // mul_signed_mode[1] -> rs1 signed, [0] -> rs2 signed
  typedef struct packed {
    logic       illegal_insn;
    logic       mul_en;
    logic       div_en;
    mul_op_e    mul_operator;
    logic [1:0] mul_signed_mode;
    div_op_e    div_operator;
  } mdu_ctrl_t;

  // Decoder starting point, nothing enabled
  parameter mdu_ctrl_t MDU_CTRL_ILLEGAL = '{
    illegal_insn:    1'b1,
    mul_en:          1'b0,
    div_en:          1'b0,
    mul_operator:    MUL_M32,
    mul_signed_mode: 2'b00,
    div_operator:    DIV_DIV
  };

  // Result payload
  typedef struct packed {
    logic [`MDU_XLEN-1:0] data;
    logic                 illegal;
  } mdu_res_t;

endpackage : mdu_pkg

//--- hdl/mdu_decoder.sv
// Combinational RV32M decoder, instruction word to control struct
`timescale 1ns/1ps
`include "mdu_macros.svh"

module mdu_decoder (
  input  logic [`MDU_XLEN-1:0] instr_i,
  output mdu_pkg::mdu_ctrl_t   ctrl_o
);

  // Instruction fields
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  always_comb begin
    // Illegal unless proven otherwise
    ctrl_o = mdu_pkg::MDU_CTRL_ILLEGAL;

    case (opcode)
      `MDU_OPCODE_OP: begin
        if (funct7 == `MDU_FUNCT7_MULDIV) begin
          // All eight funct3 values are valid RV32M ops
          ctrl_o.illegal_insn = 1'b0;
          case (funct3)
            3'b000: begin // mul
              ctrl_o.mul_en       = 1'b1;
              ctrl_o.mul_operator = mdu_pkg::MUL_M32;
            end
            3'b001: begin // mulh
              ctrl_o.mul_en          = 1'b1;
              ctrl_o.mul_operator    = mdu_pkg::MUL_H;
              ctrl_o.mul_signed_mode = 2'b11;
            end
            3'b010: begin // mulhsu
              ctrl_o.mul_en          = 1'b1;
              ctrl_o.mul_operator    = mdu_pkg::MUL_H;
              ctrl_o.mul_signed_mode = 2'b10;
            end
            3'b011: begin // mulhu
              ctrl_o.mul_en          = 1'b1;
              ctrl_o.mul_operator    = mdu_pkg::MUL_H;
              ctrl_o.mul_signed_mode = 2'b00;
            end
            3'b100: begin // div
              ctrl_o.div_en       = 1'b1;
              ctrl_o.div_operator = mdu_pkg::DIV_DIV;
            end
            3'b101: begin // divu
              ctrl_o.div_en       = 1'b1;
              ctrl_o.div_operator = mdu_pkg::DIV_DIVU;
            end
            3'b110: begin // rem
              ctrl_o.div_en       = 1'b1;
              ctrl_o.div_operator = mdu_pkg::DIV_REM;
            end
            default: begin // remu
              ctrl_o.div_en       = 1'b1;
              ctrl_o.div_operator = mdu_pkg::DIV_REMU;
            end
          endcase
        end
      end

      // Other opcodes keep the illegal default
      default: ;
    endcase
  end

endmodule : mdu_decoder

//--- hdl/mdu_divider.sv
// Iterative radix-2 restoring divider on unsigned magnitudes
`timescale 1ns/1ps
`include "mdu_macros.svh"

module mdu_divider (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 start_i,
  input  logic [`MDU_XLEN-1:0] dividend_i,
  input  logic [`MDU_XLEN-1:0] divisor_i,
  output logic                 done_o,
  output logic [`MDU_XLEN-1:0] quotient_o,
  output logic [`MDU_XLEN-1:0] remainder_o
);

  // Iterations left, zero when idle
  logic [5:0] cnt_q;
  logic       busy;
  logic       done_q;

  // Partial remainder, quotient/dividend shifter, divisor
  logic [`MDU_XLEN-1:0] rem_q;
  logic [`MDU_XLEN-1:0] quo_q;
  logic [`MDU_XLEN-1:0] dvs_q;

  // One iteration
  logic [`MDU_XLEN:0] shifted;
  logic [`MDU_XLEN:0] trial;
  logic               fits;

  assign busy = (cnt_q != 6'd0);

  //////////////////////////////////////////////////////////////////////
  // Shift-subtract step
  //////////////////////////////////////////////////////////////////////

  // Next dividend bit enters the remainder
  assign shifted = {rem_q, quo_q[`MDU_XLEN-1]};
  assign trial   = shifted - {1'b0, dvs_q};
  // No borrow, so the divisor fits
  assign fits    = ~trial[`MDU_XLEN];

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q  <= 6'd0;
      done_q <= 1'b0;
    end else begin
      // Pulse on the last iteration
      done_q <= busy && (cnt_q == 6'd1);
      if (start_i) begin
        cnt_q <= 6'(`MDU_XLEN);
      end else if (busy) begin
        cnt_q <= cnt_q - 6'd1;
      end
    end
  end

  // Datapath, held after the last step
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      rem_q <= '0;
      quo_q <= dividend_i;
      dvs_q <= divisor_i;
    end else if (busy) begin
      // Restore on borrow
      rem_q <= fits ? trial[`MDU_XLEN-1:0] : shifted[`MDU_XLEN-1:0];
      quo_q <= {quo_q[`MDU_XLEN-2:0], fits};
    end
  end

  assign done_o      = done_q;
  assign quotient_o  = quo_q;
  assign remainder_o = rem_q;

  // Caller waits for done before restarting
  start_not_busy_a: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) start_i |-> !busy
  ) else $error("divider started while busy");

endmodule : mdu_divider

//--- hdl/mdu_execute.sv
// Execute stage, single-cycle multiplier and sign-corrected divide around the divider
`timescale 1ns/1ps
`include "mdu_macros.svh"

module mdu_execute (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 valid_i,
  output logic                 ready_o,
  input  mdu_pkg::mdu_ctrl_t   ctrl_i,
  input  logic [`MDU_XLEN-1:0] rs1_i,
  input  logic [`MDU_XLEN-1:0] rs2_i,
  output logic                 valid_o,
  input  logic                 ready_i,
  output mdu_pkg::mdu_res_t    res_o
);

  localparam int XL = `MDU_XLEN;

  typedef enum logic [1:0] {S_IDLE, S_DIV, S_HOLD} state_e;

  state_e            state_q;
  logic              accept;
  mdu_pkg::mdu_res_t res_q;
  mdu_pkg::mdu_res_t single_res;

  // Multiplier
  logic signed [XL:0]     mul_a;
  logic signed [XL:0]     mul_b;
  logic signed [2*XL+1:0] mul_prod;

  // Divide setup and finish
  logic                 div_start;
  logic                 div_signed;
  logic                 a_neg;
  logic                 b_neg;
  logic [XL-1:0]        a_mag;
  logic [XL-1:0]        b_mag;
  logic                 div_done;
  logic [XL-1:0]        div_quo;
  logic [XL-1:0]        div_rem;
  logic [XL-1:0]        q_fix;
  logic [XL-1:0]        r_fix;
  logic [XL-1:0]        div_data;
  mdu_pkg::div_op_e     div_op_q;
  logic                 a_neg_q;
  logic                 b_neg_q;
  logic                 by_zero_q;
  logic                 ovf_q;
  logic [XL-1:0]        dividend_q;

  // Free when idle or the held result leaves now
  assign ready_o   = (state_q == S_IDLE) || ((state_q == S_HOLD) && ready_i);
  assign accept    = valid_i && ready_o;
  assign div_start = accept && ctrl_i.div_en;

  //////////////////////////////////////////////////////////////////////
  // Multiply, 33x33 signed
  //////////////////////////////////////////////////////////////////////

  assign mul_a    = {ctrl_i.mul_signed_mode[1] & rs1_i[XL-1], rs1_i};
  assign mul_b    = {ctrl_i.mul_signed_mode[0] & rs2_i[XL-1], rs2_i};
  assign mul_prod = mul_a * mul_b;

  // Zero data unless a multiply
  always_comb begin
    single_res.illegal = ctrl_i.illegal_insn;
    if (!ctrl_i.mul_en) begin
      single_res.data = '0;
    end else if (ctrl_i.mul_operator == mdu_pkg::MUL_H) begin
      single_res.data = mul_prod[2*XL-1:XL];
    end else begin
      single_res.data = mul_prod[XL-1:0];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Divide, magnitudes in and sign fix out
  //////////////////////////////////////////////////////////////////////

  assign div_signed = (ctrl_i.div_operator == mdu_pkg::DIV_DIV) ||
                      (ctrl_i.div_operator == mdu_pkg::DIV_REM);
  assign a_neg      = div_signed & rs1_i[XL-1];
  assign b_neg      = div_signed & rs2_i[XL-1];
  assign a_mag      = a_neg ? -rs1_i : rs1_i;
  assign b_mag      = b_neg ? -rs2_i : rs2_i;

  mdu_divider mdu_divider_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .start_i     (div_start),
    .dividend_i  (a_mag),
    .divisor_i   (b_mag),
    .done_o      (div_done),
    .quotient_o  (div_quo),
    .remainder_o (div_rem)
  );

  always_comb begin
    // Quotient negative on sign mismatch, remainder follows dividend
    q_fix = (a_neg_q ^ b_neg_q) ? -div_quo : div_quo;
    r_fix = a_neg_q ? -div_rem : div_rem;
    if (by_zero_q) begin
      q_fix = '1;
      r_fix = dividend_q;
    end
    if (ovf_q) begin
      // Most negative / -1
      q_fix = dividend_q;
      r_fix = '0;
    end
    if ((div_op_q == mdu_pkg::DIV_REM) || (div_op_q == mdu_pkg::DIV_REMU)) begin
      div_data = r_fix;
    end else begin
      div_data = q_fix;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // FSM and result register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= S_IDLE;
    end else begin
      case (state_q)
        S_DIV: begin
          if (div_done) state_q <= S_HOLD;
        end
        default: begin
          if (accept) begin
            state_q <= ctrl_i.div_en ? S_DIV : S_HOLD;
          end else if ((state_q == S_HOLD) && ready_i) begin
            state_q <= S_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    // Divide context captured with the divider start
    if (div_start) begin
      div_op_q   <= ctrl_i.div_operator;
      a_neg_q    <= a_neg;
      b_neg_q    <= b_neg;
      by_zero_q  <= div_signed && (rs2_i == '0);
      ovf_q      <= div_signed && (rs1_i == {1'b1, {(XL-1){1'b0}}}) && (rs2_i == '1);
      dividend_q <= rs1_i;
    end
    if (accept && !ctrl_i.div_en) begin
      res_q <= single_res;
    end else if ((state_q == S_DIV) && div_done) begin
      res_q <= '{data: div_data, illegal: 1'b0};
    end
  end

  assign valid_o = (state_q == S_HOLD);
  assign res_o   = res_q;

  // Stalled result holds across the divider and FSM
  res_hold_a: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(res_o)
  ) else $error("execute result changed under stall");

endmodule : mdu_execute

//--- hdl/mdu_result.sv
// One-entry registered output buffer with valid/ready toward the consumer
`timescale 1ns/1ps

module mdu_result (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              valid_i,
  output logic              ready_o,
  input  mdu_pkg::mdu_res_t res_i,
  output logic              res_valid_o,
  input  logic              res_ready_i,
  output mdu_pkg::mdu_res_t res_o
);

  logic              full_q;
  logic              load;
  mdu_pkg::mdu_res_t res_q;

  //////////////////////////////////////////////////////////////////////
  // Entry control
  //////////////////////////////////////////////////////////////////////

  // Room when empty or draining this cycle
  assign ready_o = ~full_q | res_ready_i;
  assign load    = valid_i & ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      full_q <= 1'b0;
    end else if (load) begin
      // Load wins over drain
      full_q <= 1'b1;
    end else if (res_ready_i) begin
      full_q <= 1'b0;
    end
  end

  // Payload
  always_ff @(posedge clk_i) begin
    if (load) begin
      res_q <= res_i;
    end
  end

  assign res_valid_o = full_q;
  assign res_o       = res_q;

  // Offered result stays put until taken
  out_hold_a: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    res_valid_o && !res_ready_i |=> res_valid_o && $stable(res_o)
  ) else $error("output result dropped or changed under stall");

endmodule : mdu_result

//--- hdl/mdu_top.sv
// Top level of the RV32M unit, decode into execute into result buffer
`timescale 1ns/1ps

module mdu_top (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  mdu_pkg::mdu_req_t req_i,
  output logic              res_valid_o,
  input  logic              res_ready_i,
  output mdu_pkg::mdu_res_t res_o
);

  // Decode to execute
  mdu_pkg::mdu_ctrl_t ctrl;

  // Execute to result
  logic              ex_valid;
  logic              ex_ready;
  mdu_pkg::mdu_res_t ex_res;

  mdu_decoder mdu_decoder_i (
    .instr_i (req_i.instr),
    .ctrl_o  (ctrl)
  );

  // Operands bypass the decoder
  mdu_execute mdu_execute_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (req_valid_i),
    .ready_o  (req_ready_o),
    .ctrl_i   (ctrl),
    .rs1_i    (req_i.rs1),
    .rs2_i    (req_i.rs2),
    .valid_o  (ex_valid),
    .ready_i  (ex_ready),
    .res_o    (ex_res)
  );

  mdu_result mdu_result_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .valid_i     (ex_valid),
    .ready_o     (ex_ready),
    .res_i       (ex_res),
    .res_valid_o (res_valid_o),
    .res_ready_i (res_ready_i),
    .res_o       (res_o)
  );

endmodule : mdu_top

//--- tests/tb_mdu.sv
// Directed testbench for the RV32M unit with reference model, compare tasks and watchdog
`timescale 1ns/1ps
`include "mdu_macros.svh"

module tb_mdu;

  localparam int CLK_PERIOD  = 100;
  localparam int REQ_TIMEOUT = 200;
  localparam int MUL_RAND    = 20;
  localparam int DIV_RAND    = 10;
  localparam int STREAM_LEN  = 16;
  // Corners, random mul, random div, specials, illegal, back-pressure, stream
  localparam int NUM_REQ = 4*16 + 4*MUL_RAND + 4*DIV_RAND + 12 + 4 + 5 + STREAM_LEN;
  localparam int WATCHDOG_CYCLES = NUM_REQ*40 + 100;

  logic              clk_i;
  logic              arst_n_i;
  logic              req_valid_i;
  logic              req_ready_o;
  mdu_pkg::mdu_req_t req_i;
  logic              res_valid_o;
  logic              res_ready_i;
  mdu_pkg::mdu_res_t res_o;

  // Scoreboard state
  mdu_pkg::mdu_res_t exp_q[$];
  mdu_pkg::mdu_res_t mon_exp;
  int                rx_cycle_q[$];
  int                cycle_cnt;
  int                rx_idx;
  int                errors;
  int                sent;
  integer            seed;
  string             test_name;

  mdu_top mdu_top_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_i       (req_i),
    .res_valid_o (res_valid_o),
    .res_ready_i (res_ready_i),
    .res_o       (res_o)
  );

  always #(CLK_PERIOD/2) clk_i = ~clk_i;

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  //////////////////////////////////////////////////////////////////////
  // Reference model and instruction encoding
  //////////////////////////////////////////////////////////////////////

  // R-type word, register fields fixed
  function automatic logic [31:0] rtype(input logic [6:0] funct7, input logic [2:0] funct3,
                                        input logic [6:0] opcode);
    rtype = {funct7, 5'd2, 5'd1, funct3, 5'd3, opcode};
  endfunction

  function automatic mdu_pkg::mdu_res_t ref_model(input logic [31:0] instr,
                                                  input logic [31:0] a, input logic [31:0] b);
    mdu_pkg::mdu_res_t r;
    logic [63:0]       ea;
    logic [63:0]       eb;
    logic [63:0]       prod;
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic signed [31:0] sq;
    logic signed [31:0] sr;
    logic [2:0]        f3;
    logic              ovf;
    r.data    = '0;
    r.illegal = 1'b1;
    f3        = instr[14:12];
    sa        = a;
    sb        = b;
    sq        = '0;
    sr        = '0;
    ovf       = (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF);
    // Signed quotient and remainder, truncated toward zero
    if ((b != 0) && !ovf) begin
      sq = sa / sb;
      sr = sa % sb;
    end
    if ((instr[6:0] == `MDU_OPCODE_OP) && (instr[31:25] == `MDU_FUNCT7_MULDIV)) begin
      r.illegal = 1'b0;
      // Full 64-bit product of extended operands
      ea   = (f3 == 3'd1 || f3 == 3'd2) ? {{32{a[31]}}, a} : {32'b0, a};
      eb   = (f3 == 3'd1) ? {{32{b[31]}}, b} : {32'b0, b};
      prod = ea * eb;
      case (f3)
        3'd0: r.data = prod[31:0];
        3'd1, 3'd2, 3'd3: r.data = prod[63:32];
        3'd4: r.data = (b == 0) ? 32'hFFFF_FFFF : (ovf ? a : sq);
        3'd5: r.data = (b == 0) ? 32'hFFFF_FFFF : a / b;
        3'd6: r.data = (b == 0) ? a : (ovf ? 32'h0 : sr);
        default: r.data = (b == 0) ? a : a % b;
      endcase
    end
    ref_model = r;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_res(input mdu_pkg::mdu_res_t got, input mdu_pkg::mdu_res_t exp,
                           input string msg);
    if (got !== exp) begin
      $display("[FAIL] %0t: %s got data=%h illegal=%b, expected data=%h illegal=%b",
               $time, msg, got.data, got.illegal, exp.data, exp.illegal);
      errors++;
    end
  endtask

  // Flag set and data zero
  task automatic check_illegal(input mdu_pkg::mdu_res_t got, input string msg);
    if (got.illegal !== 1'b1 || got.data !== '0) begin
      $display("[FAIL] %0t: %s illegal result wrong, data=%h illegal=%b",
               $time, msg, got.data, got.illegal);
      errors++;
    end
  endtask

  // Response monitor, values stable at the falling edge
  always @(negedge clk_i) begin
    if (arst_n_i && res_valid_o && res_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("Result arrived at %0t with no request outstanding", $time);
        errors++;
      end else begin
        mon_exp = exp_q.pop_front();
        if (mon_exp.illegal) begin
          check_illegal(res_o, $sformatf("%s result %0d", test_name, rx_idx));
        end else begin
          check_res(res_o, mon_exp, $sformatf("%s result %0d", test_name, rx_idx));
        end
        rx_cycle_q.push_back(cycle_cnt);
      end
      rx_idx++;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Request and drain helpers, entered 1 ns after a rising edge
  //////////////////////////////////////////////////////////////////////

  task automatic send_req(input logic [31:0] instr, input logic [31:0] a,
                          input logic [31:0] b);
    int waited;
    waited = 0;
    exp_q.push_back(ref_model(instr, a, b));
    req_i.instr = instr;
    req_i.rs1   = a;
    req_i.rs2   = b;
    req_valid_i = 1'b1;
    sent++;
    @(negedge clk_i);
    while (!req_ready_o && waited < REQ_TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    if (!req_ready_o) begin
      $display("Request %0d in %s was never accepted", sent, test_name);
      errors++;
    end
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < REQ_TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("%s: %0d results never came out", test_name, exp_q.size());
      errors++;
      exp_q.delete();
    end
    @(posedge clk_i);
    #1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic mul_corners();
    logic [31:0] corners [4];
    corners   = '{32'h0, 32'h1, 32'hFFFF_FFFF, 32'h8000_0000};
    test_name = "mul corners";
    for (int f = 0; f < 4; f++) begin
      for (int i = 0; i < 4; i++) begin
        for (int j = 0; j < 4; j++) begin
          send_req(rtype(`MDU_FUNCT7_MULDIV, f[2:0], `MDU_OPCODE_OP), corners[i], corners[j]);
        end
      end
    end
    wait_drain();
  endtask

  task automatic mul_random();
    logic [31:0] a;
    logic [31:0] b;
    test_name = "mul random";
    for (int f = 0; f < 4; f++) begin
      for (int i = 0; i < MUL_RAND; i++) begin
        a = $random(seed);
        b = $random(seed);
        send_req(rtype(`MDU_FUNCT7_MULDIV, f[2:0], `MDU_OPCODE_OP), a, b);
      end
    end
    wait_drain();
  endtask

  task automatic div_random();
    logic [31:0] a;
    logic [31:0] b;
    test_name = "div random";
    for (int f = 4; f < 8; f++) begin
      for (int i = 0; i < DIV_RAND; i++) begin
        a = $random(seed);
        b = $random(seed);
        // Small divisors on even steps for larger quotients
        if (i % 2 == 0) b = b >> (i * 3);
        if (b == 0) b = 32'd7;
        send_req(rtype(`MDU_FUNCT7_MULDIV, f[2:0], `MDU_OPCODE_OP), a, b);
      end
    end
    wait_drain();
  endtask

  // Divide by zero and most negative over minus one
  task automatic div_special();
    test_name = "div special";
    for (int f = 4; f < 8; f++) begin
      send_req(rtype(`MDU_FUNCT7_MULDIV, f[2:0], `MDU_OPCODE_OP), 32'h1234_5678, 32'h0);
      send_req(rtype(`MDU_FUNCT7_MULDIV, f[2:0], `MDU_OPCODE_OP), 32'h8000_0001, 32'h0);
      send_req(rtype(`MDU_FUNCT7_MULDIV, f[2:0], `MDU_OPCODE_OP), 32'h8000_0000,
               32'hFFFF_FFFF);
    end
    wait_drain();
  endtask

  task automatic illegal_ops();
    test_name = "illegal";
    send_req(rtype(`MDU_FUNCT7_MULDIV, 3'd0, 7'b001_0011), 32'd5, 32'd6);
    send_req(rtype(`MDU_FUNCT7_MULDIV, 3'd4, 7'b000_0011), 32'd5, 32'd6);
    send_req(rtype(7'b000_0000, 3'd0, `MDU_OPCODE_OP), 32'd5, 32'd6);
    send_req(rtype(7'b010_0000, 3'd5, `MDU_OPCODE_OP), 32'd5, 32'd6);
    wait_drain();
  endtask

  // Consumer stalls across a division
  task automatic backpressure();
    test_name   = "back-pressure";
    res_ready_i = 1'b0;
    fork
      begin
        send_req(rtype(`MDU_FUNCT7_MULDIV, 3'd0, `MDU_OPCODE_OP), 32'd12, 32'd13);
        send_req(rtype(`MDU_FUNCT7_MULDIV, 3'd4, `MDU_OPCODE_OP), 32'hFFFF_FF9C, 32'd7);
        send_req(rtype(`MDU_FUNCT7_MULDIV, 3'd1, `MDU_OPCODE_OP), 32'h8000_0000, 32'd3);
        send_req(rtype(7'b000_0000, 3'd0, `MDU_OPCODE_OP), 32'd1, 32'd2);
        send_req(rtype(`MDU_FUNCT7_MULDIV, 3'd7, `MDU_OPCODE_OP), 32'd1000, 32'd33);
      end
      begin
        repeat (60) @(negedge clk_i);
        if (req_ready_o !== 1'b0 || res_valid_o !== 1'b1) begin
          $display("[FAIL] %0t: %s req_ready_o=%b res_valid_o=%b during stall",
                   $time, test_name, req_ready_o, res_valid_o);
          errors++;
        end
        @(posedge clk_i);
        #1;
        res_ready_i = 1'b1;
      end
    join
    wait_drain();
  endtask

  // Single-cycle ops at full rate
  task automatic mul_stream();
    logic [31:0] a;
    logic [31:0] b;
    test_name = "stream";
    rx_cycle_q.delete();
    for (int k = 0; k < STREAM_LEN; k++) begin
      a = $random(seed);
      b = $random(seed);
      send_req(rtype(`MDU_FUNCT7_MULDIV, 3'(k % 4), `MDU_OPCODE_OP), a, b);
    end
    wait_drain();
    if (rx_cycle_q.size() != STREAM_LEN) begin
      $display("%s: %0d results seen, %0d sent", test_name, rx_cycle_q.size(), STREAM_LEN);
      errors++;
    end
    for (int k = 1; k < rx_cycle_q.size(); k++) begin
      if (rx_cycle_q[k] != rx_cycle_q[k-1] + 1) begin
        $display("[FAIL] %0t: %s gap of %0d cycles before result %0d",
                 $time, test_name, rx_cycle_q[k] - rx_cycle_q[k-1], k);
        errors++;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    clk_i       = 1'b0;
    arst_n_i    = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    res_ready_i = 1'b1;
    cycle_cnt   = 0;
    rx_idx      = 0;
    errors      = 0;
    sent        = 0;
    seed        = 69;
    test_name   = "reset";
    repeat (5) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    @(negedge clk_i);
    if (req_ready_o !== 1'b1 || res_valid_o !== 1'b0) begin
      $display("[FAIL] %0t: after reset req_ready_o=%b res_valid_o=%b",
               $time, req_ready_o, res_valid_o);
      errors++;
    end
    @(posedge clk_i);
    #1;
    mul_corners();
    mul_random();
    div_random();
    div_special();
    illegal_ops();
    backpressure();
    mul_stream();
    $display("Errors: %0d, requests: %0d, results: %0d", errors, sent, rx_idx);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles in %s", WATCHDOG_CYCLES, test_name);
    $display("Test FAILED");
    $finish;
  end

endmodule : tb_mdu

//--- project.f
+incdir+include
hdl/mdu_pkg.sv
hdl/mdu_decoder.sv
hdl/mdu_divider.sv
hdl/mdu_execute.sv
hdl/mdu_result.sv
hdl/mdu_top.sv
tests/tb_mdu.sv

//--- Bender.yml
package:
  name: mdu

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/mdu_pkg.sv
      - hdl/mdu_decoder.sv
      - hdl/mdu_divider.sv
      - hdl/mdu_execute.sv
      - hdl/mdu_result.sv
      - hdl/mdu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_mdu.sv
